// ==== source/cmd_seq_consts.svh ====
// command memory size, register map, version and start latency
`ifndef CMD_SEQ_CONSTS_SVH
`define CMD_SEQ_CONSTS_SVH

`define CMD_MEM_BYTES 256 // command memory depth in bytes
`define CMD_MEM_BASE 16 // bus address of memory byte 0

// register map, multi-byte fields little-endian
`define ADDR_RESET 0
`define ADDR_START 1
`define ADDR_CONF 2
`define ADDR_SIZE 3
`define ADDR_REPEAT 5
`define ADDR_START_REP 9
`define ADDR_STOP_REP 11

`define CMD_SEQ_VERSION 1

`define CMD_SEQ_LATENCY 3 // start write to first encoded pair

`endif

// ==== source/cmd_bus_pkg.sv ====
// register bus address, data and request types
`default_nettype none

package cmd_bus_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    // one bus access, wr and rd are single-cycle strobes
    typedef struct packed {
        bus_addr_t add;
        bus_data_t data;
        logic wr;
        logic rd;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== source/cmd_seq_pkg.sv ====
// sequencer configuration, state and counter types
`default_nettype none

package cmd_seq_pkg;

    typedef logic [15:0] bit_cnt_t; // bit count or bit index
    typedef logic [31:0] rep_cnt_t;
    typedef logic [1:0] line_mode_t; // plain, half-bit delay, ieee, thomas

    typedef struct packed {
        bit_cnt_t cmd_size;
        rep_cnt_t repeat_count;
        bit_cnt_t start_repeat; // preamble length
        bit_cnt_t stop_repeat; // tail length
        line_mode_t mode;
        logic en_ext_start;
        logic dis_clock_gate;
        logic dis_cmd_pulse;
    } seq_cfg_t;

    typedef enum logic {
        SEQ_WAIT,
        SEQ_SEND
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/cmd_seq_regs.sv ====
// register bank, command memory, bus readback and finish status
`timescale 1ns/10ps
`default_nettype none
`include "cmd_seq_consts.svh"

module cmd_seq_regs (
    input wire CMD_CLK_IN,
    input wire RST_CMD_CLK,
    input wire cmd_bus_pkg::bus_req_t req,
    output cmd_bus_pkg::bus_data_t rd_data,
    output cmd_seq_pkg::seq_cfg_t cfg,
    output logic start,
    output logic soft_rst,
    input wire [$clog2(`CMD_MEM_BYTES)-1:0] mem_addr,
    output cmd_bus_pkg::bus_data_t mem_data,
    input wire ready
);
    import cmd_bus_pkg::*;

    localparam int MEM_AW = $clog2(`CMD_MEM_BYTES);

    bus_data_t conf [`ADDR_CONF:`ADDR_STOP_REP+1];
    bus_data_t cmd_mem [`CMD_MEM_BYTES];
    bus_addr_t mem_off;
    logic [MEM_AW-1:0] mem_idx;
    logic mem_sel;
    logic conf_sel;
    logic finish;
    logic ready_q;

    assign soft_rst = req.wr && (req.add == `ADDR_RESET);
    assign start = req.wr && (req.add == `ADDR_START);

    assign conf_sel = (req.add >= `ADDR_CONF) && (req.add <= `ADDR_STOP_REP + 1);
    assign mem_sel = (req.add >= `CMD_MEM_BASE) && (req.add < `CMD_MEM_BASE + `CMD_MEM_BYTES);
    assign mem_off = req.add - bus_addr_t'(`CMD_MEM_BASE);
    assign mem_idx = mem_off[MEM_AW-1:0];

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            for (int i = `ADDR_CONF; i <= `ADDR_STOP_REP + 1; i++) begin
                conf[i] <= (i == `ADDR_REPEAT) ? 8'd1 : 8'd0; // one pass by default
            end
        end else if (req.wr && conf_sel) begin
            conf[req.add[3:0]] <= req.data;
        end
    end

    assign cfg.cmd_size = {conf[`ADDR_SIZE+1], conf[`ADDR_SIZE]};
    assign cfg.repeat_count = {conf[`ADDR_REPEAT+3], conf[`ADDR_REPEAT+2],
                               conf[`ADDR_REPEAT+1], conf[`ADDR_REPEAT]};
    assign cfg.start_repeat = {conf[`ADDR_START_REP+1], conf[`ADDR_START_REP]};
    assign cfg.stop_repeat = {conf[`ADDR_STOP_REP+1], conf[`ADDR_STOP_REP]};
    assign cfg.dis_cmd_pulse = conf[`ADDR_CONF][4];
    assign cfg.dis_clock_gate = conf[`ADDR_CONF][3];
    assign cfg.mode = conf[`ADDR_CONF][2:1];
    assign cfg.en_ext_start = conf[`ADDR_CONF][0];

    always_ff @(posedge CMD_CLK_IN) begin
        if (req.wr && mem_sel) begin
            cmd_mem[mem_idx] <= req.data;
        end
    end

    assign mem_data = cmd_mem[mem_addr]; // async read, core registers the byte

    // finish clears on start, sets when the core returns to ready
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            ready_q <= 1'b1;
            finish <= 1'b1;
        end else begin
            ready_q <= ready;
            if (start) begin
                finish <= 1'b0;
            end else if (ready && !ready_q) begin
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (req.rd) begin
            if (req.add == `ADDR_RESET) begin
                rd_data <= bus_data_t'(`CMD_SEQ_VERSION);
            end else if (req.add == `ADDR_START) begin
                rd_data <= {7'b0, finish};
            end else if (conf_sel) begin
                rd_data <= conf[req.add[3:0]];
            end else if (mem_sel) begin
                rd_data <= cmd_mem[mem_idx];
            end else begin
                rd_data <= '0;
            end
        end
    end

    a_no_rd_wr: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        !(req.rd && req.wr));

endmodule

`default_nettype wire

// ==== source/cmd_seq_core.sv ====
// sequencer FSM, bit and repeat counters, memory address and serializer
`timescale 1ns/10ps
`default_nettype none
`include "cmd_seq_consts.svh"

module cmd_seq_core (
    input wire CMD_CLK_IN,
    input wire RST_CMD_CLK,
    input wire soft_rst,
    input wire cmd_seq_pkg::seq_cfg_t cfg,
    input wire start,
    input wire ext_start,
    output logic [$clog2(`CMD_MEM_BYTES)-1:0] mem_addr,
    input wire cmd_bus_pkg::bus_data_t mem_data,
    output logic ser_bit,
    output logic ser_valid,
    output logic ready,
    output logic cmd_start_flag
);
    import cmd_bus_pkg::*;
    import cmd_seq_pkg::*;

    localparam int MEM_AW = $clog2(`CMD_MEM_BYTES);

    seq_state_t state;
    bit_cnt_t cnt; // index of the bit being fetched
    rep_cnt_t rep_cnt;
    rep_cnt_t rep_total;
    bit_cnt_t mid_last;
    bit_cnt_t seq_last;
    bus_data_t shift_byte;
    logic go;
    logic fetch_valid;
    logic rep_jump;
    logic seq_done;
    logic jumped;
    logic load_byte;
    logic first_mid;
    logic flag_q;

    assign go = (state == SEQ_WAIT) && (start || (ext_start && cfg.en_ext_start));
    assign fetch_valid = (state == SEQ_SEND);

    assign rep_total = (cfg.repeat_count == '0) ? rep_cnt_t'(1) : cfg.repeat_count;
    assign mid_last = cfg.cmd_size - cfg.stop_repeat - bit_cnt_t'(1);
    assign seq_last = cfg.cmd_size - bit_cnt_t'(1);

    assign rep_jump = fetch_valid && (cnt == mid_last) && (rep_cnt < rep_total);
    assign seq_done = fetch_valid && !rep_jump && (cnt == seq_last);
    assign first_mid = fetch_valid && (cnt == cfg.start_repeat) && !cfg.dis_cmd_pulse;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            state <= SEQ_WAIT;
            cnt <= '0;
            rep_cnt <= '0;
            jumped <= 1'b0;
        end else begin
            jumped <= rep_jump;
            if (go) begin
                state <= SEQ_SEND;
                cnt <= '0;
                rep_cnt <= rep_cnt_t'(1);
            end else if (rep_jump) begin
                cnt <= cfg.start_repeat; // back to first middle bit
                rep_cnt <= rep_cnt + rep_cnt_t'(1);
            end else if (seq_done) begin
                state <= SEQ_WAIT;
            end else if (fetch_valid) begin
                cnt <= cnt + bit_cnt_t'(1);
            end
        end
    end

    assign mem_addr = cnt[MEM_AW+2:3];

    // reload on byte boundary or after a jump into mid-byte
    assign load_byte = jumped || (cnt[2:0] == 3'd0);

    always_ff @(posedge CMD_CLK_IN) begin
        if (load_byte) begin
            shift_byte <= mem_data << cnt[2:0];
        end else begin
            shift_byte <= shift_byte << 1;
        end
    end

    assign ser_bit = shift_byte[7]; // msb first

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            ser_valid <= 1'b0;
            flag_q <= 1'b0;
            cmd_start_flag <= 1'b0;
            ready <= 1'b1;
        end else begin
            ser_valid <= fetch_valid;
            flag_q <= first_mid;
            cmd_start_flag <= flag_q; // extra stage matches the encoder register
            ready <= !(go || fetch_valid || ser_valid);
        end
    end

    a_valid_in_send: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        ser_valid |-> !ready);

    a_flag_in_send: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        cmd_start_flag |-> !ready);

    a_cnt_in_range: assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        fetch_valid |-> cnt <= seq_last);

endmodule

`default_nettype wire

// ==== source/cmd_line_encoder.sv ====
// line encoder, two half-bit samples per clock for a DDR pad
`timescale 1ns/10ps
`default_nettype none

module cmd_line_encoder (
    input wire CMD_CLK_IN,
    input wire RST_CMD_CLK,
    input wire cmd_seq_pkg::line_mode_t mode,
    input wire ser_bit,
    input wire ser_valid,
    output logic [1:0] cmd_data_pair // bit 1 goes out first
);

    logic line_bit;
    logic prev_bit;

    assign line_bit = ser_valid & ser_bit; // idle line encodes a 0

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            prev_bit <= 1'b0;
            cmd_data_pair <= 2'b00;
        end else begin
            prev_bit <= line_bit;
            case (mode)
                2'd0: cmd_data_pair <= {line_bit, line_bit};
                2'd1: cmd_data_pair <= {prev_bit, line_bit}; // half-bit late
                2'd2: cmd_data_pair <= {~line_bit, line_bit}; // ieee 802.3
                default: cmd_data_pair <= {line_bit, ~line_bit}; // thomas
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/cmd_seq_top.sv ====
// command sequencer top with registers, core and line encoder
`timescale 1ns/10ps
`default_nettype none
`include "cmd_seq_consts.svh"

module cmd_seq_top (
    input wire CMD_CLK_IN,
    input wire RST_CMD_CLK,
    input wire cmd_bus_pkg::bus_req_t req,
    output cmd_bus_pkg::bus_data_t rd_data,
    input wire ext_start,
    output logic ext_start_enable,
    output logic [1:0] cmd_data_pair,
    output logic cmd_clk_en,
    output logic cmd_ready,
    output logic cmd_start_flag
);
    import cmd_bus_pkg::*;
    import cmd_seq_pkg::*;

    seq_cfg_t cfg;
    bus_data_t mem_data;
    logic [$clog2(`CMD_MEM_BYTES)-1:0] mem_addr;
    logic start;
    logic soft_rst;
    logic ser_bit;
    logic ser_valid;

    assign ext_start_enable = cfg.en_ext_start;
    assign cmd_clk_en = !cfg.dis_clock_gate; // forwarded clock runs unless gated off

    cmd_seq_regs u_regs (
        .CMD_CLK_IN(CMD_CLK_IN),
        .RST_CMD_CLK(RST_CMD_CLK),
        .req(req),
        .rd_data(rd_data),
        .cfg(cfg),
        .start(start),
        .soft_rst(soft_rst),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .ready(cmd_ready)
    );

    cmd_seq_core u_core (
        .CMD_CLK_IN(CMD_CLK_IN),
        .RST_CMD_CLK(RST_CMD_CLK),
        .soft_rst(soft_rst),
        .cfg(cfg),
        .start(start),
        .ext_start(ext_start),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .ser_bit(ser_bit),
        .ser_valid(ser_valid),
        .ready(cmd_ready),
        .cmd_start_flag(cmd_start_flag)
    );

    cmd_line_encoder u_encoder (
        .CMD_CLK_IN(CMD_CLK_IN),
        .RST_CMD_CLK(RST_CMD_CLK),
        .mode(cfg.mode),
        .ser_bit(ser_bit),
        .ser_valid(ser_valid),
        .cmd_data_pair(cmd_data_pair)
    );

endmodule

`default_nettype wire

// ==== tests/tb_cmd_seq.sv ====
// testbench for the command sequencer, case file driven
`timescale 1ns/10ps
`default_nettype none
`include "cmd_seq_consts.svh"

module tb_cmd_seq;
    import cmd_bus_pkg::*;

    localparam int MAX_CASES = 16;

    logic clk;
    logic rst;
    bus_req_t req;
    bus_data_t rd_data;
    logic ext_start;
    logic ext_start_enable;
    logic [1:0] cmd_data_pair;
    logic cmd_clk_en;
    logic cmd_ready;
    logic cmd_start_flag;

    logic [7:0] c_conf [MAX_CASES];
    logic [15:0] c_size [MAX_CASES];
    logic [31:0] c_rep [MAX_CASES];
    logic [15:0] c_srep [MAX_CASES];
    logic [15:0] c_erep [MAX_CASES];
    logic [31:0] c_mem [MAX_CASES];
    int c_len [MAX_CASES];
    logic [255:0] c_pairs [MAX_CASES];
    logic [127:0] c_flags [MAX_CASES];
    int n_cases;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles;
    int cycle_limit;

    cmd_seq_top u_cmd_seq_top (
        .CMD_CLK_IN(clk),
        .RST_CMD_CLK(rst),
        .req(req),
        .rd_data(rd_data),
        .ext_start(ext_start),
        .ext_start_enable(ext_start_enable),
        .cmd_data_pair(cmd_data_pair),
        .cmd_clk_en(cmd_clk_en),
        .cmd_ready(cmd_ready),
        .cmd_start_flag(cmd_start_flag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit, raised once the cases are known
    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        @(posedge clk);
        wait (cycles > cycle_limit);
        $display("timeout after %0d cycles, the DUT never finished", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic check_data(input bus_data_t got, input bus_data_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pair(input logic [1:0] got, input logic [1:0] exp, input int k);
        if (got !== exp) begin
            $display("FAILED %0t: pair %0d is %b, expected %b", $time, k, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t d);
        @(posedge clk);
        req <= '{add: a, data: d, wr: 1'b1, rd: 1'b0};
        @(posedge clk);
        req <= '0;
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_data_t d);
        @(posedge clk);
        req <= '{add: a, data: '0, wr: 1'b0, rd: 1'b1};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - err_before);
        end
    endtask

    task automatic load_cases();
        int fd;
        int n;
        string line;
        fd = $fopen("tests/cmd_seq_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/cmd_seq_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", c_conf[n_cases],
                            c_size[n_cases], c_rep[n_cases], c_srep[n_cases],
                            c_erep[n_cases], c_mem[n_cases], c_len[n_cases],
                            c_pairs[n_cases], c_flags[n_cases]);
                if (n == 9) begin
                    cycle_limit += c_len[n_cases] + 80; // bus setup plus stream
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int i);
        int err_before;
        int cyc;
        int low;
        int k;
        bit done;
        bus_data_t d;
        err_before = errors;
        bus_write(`ADDR_CONF, c_conf[i]);
        bus_write(`ADDR_SIZE, c_size[i][7:0]);
        bus_write(`ADDR_SIZE + 1, c_size[i][15:8]);
        for (int b = 0; b < 4; b++) begin
            bus_write(`ADDR_REPEAT + b, c_rep[i][8*b +: 8]);
            bus_write(`CMD_MEM_BASE + b, c_mem[i][31 - 8*b -: 8]); // byte 0 is msb
        end
        bus_write(`ADDR_START_REP, c_srep[i][7:0]);
        bus_write(`ADDR_START_REP + 1, c_srep[i][15:8]);
        bus_write(`ADDR_STOP_REP, c_erep[i][7:0]);
        bus_write(`ADDR_STOP_REP + 1, c_erep[i][15:8]);
        bus_read(`ADDR_CONF, d);
        check_data(d, c_conf[i], "conf register");
        bus_read(`ADDR_SIZE, d);
        check_data(d, c_size[i][7:0], "size low byte");
        bus_read(`ADDR_REPEAT, d);
        check_data(d, c_rep[i][7:0], "repeat low byte");
        bus_read(`CMD_MEM_BASE, d);
        check_data(d, c_mem[i][31:24], "memory byte 0");

        @(posedge clk);
        req <= '{add: `ADDR_START, data: '0, wr: 1'b1, rd: 1'b0};
        cyc = 0;
        low = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            k = cyc - `CMD_SEQ_LATENCY;
            if (cyc >= 1 && !cmd_ready) low++;
            if (k >= 0 && k < c_len[i]) begin
                check_pair(cmd_data_pair, c_pairs[i][2*(c_len[i]-1-k) +: 2], k);
                check_flag(cmd_start_flag, c_flags[i][c_len[i]-1-k], "start flag");
            end else if (cyc >= 1) begin
                check_flag(cmd_start_flag, 1'b0, "start flag outside stream");
            end
            if (cyc == 2) check_data(rd_data, 8'h00, "finish while sending");
            if (cyc >= 1 && cmd_ready) done = 1'b1;
            @(posedge clk);
            if (cyc == 0) begin
                req <= '{add: `ADDR_START, data: '0, wr: 1'b0, rd: 1'b1};
            end else begin
                req <= '0;
            end
            cyc++;
        end
        check_count(low, c_len[i] + `CMD_SEQ_LATENCY - 1, "ready low cycles");
        bus_read(`ADDR_START, d);
        check_data(d, 8'h01, "finish after sending");
        report($sformatf("case %0d", i), err_before);
    endtask

    task automatic run_ext_and_soft_reset();
        int err_before;
        bus_data_t d;
        err_before = errors;
        bus_write(`ADDR_CONF, 8'h00);
        @(posedge clk);
        ext_start <= 1'b1;
        @(posedge clk);
        ext_start <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag(cmd_ready, 1'b1, "ready with external start disabled");
        end
        bus_write(`ADDR_CONF, 8'h09); // external start on, forwarded clock off
        @(negedge clk);
        check_flag(ext_start_enable, 1'b1, "external start enable");
        check_flag(cmd_clk_en, 1'b0, "clock enable with dis_clock_gate set");
        @(posedge clk);
        ext_start <= 1'b1;
        @(posedge clk);
        ext_start <= 1'b0;
        @(negedge clk);
        check_flag(cmd_ready, 1'b0, "ready after external start");
        repeat (4) @(posedge clk);
        bus_write(`ADDR_RESET, 8'h00); // soft reset mid-sequence
        @(negedge clk);
        check_flag(cmd_ready, 1'b1, "ready after soft reset");
        check_flag(cmd_clk_en, 1'b1, "clock enable after soft reset");
        check_flag(ext_start_enable, 1'b0, "external start enable after soft reset");
        bus_read(`ADDR_START, d);
        check_data(d, 8'h01, "finish after soft reset");
        bus_read(`ADDR_CONF, d);
        check_data(d, 8'h00, "conf after soft reset");
        report("external start and soft reset", err_before);
    endtask

    initial begin
        bus_data_t d;
        int err_before;
        rst = 1'b1;
        req = '0;
        ext_start = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        cycle_limit = 400;
        n_cases = 0;
        void'($urandom(32'h231b64ec));
        load_cases();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        err_before = errors;
        bus_read(`ADDR_RESET, d);
        check_data(d, bus_data_t'(`CMD_SEQ_VERSION), "version");
        bus_read(`ADDR_START, d);
        check_data(d, 8'h01, "finish after reset");
        bus_read(`ADDR_CONF, d);
        check_data(d, 8'h00, "conf after reset");
        bus_read(`ADDR_REPEAT, d);
        check_data(d, 8'h01, "repeat after reset");
        bus_read(`ADDR_SIZE, d);
        check_data(d, 8'h00, "size after reset");
        check_flag(cmd_ready, 1'b1, "ready after reset");
        check_flag(cmd_clk_en, 1'b1, "clock enable after reset");
        report("register readback", err_before);

        for (int i = 0; i < n_cases; i++) begin
            repeat ($urandom % 4) @(posedge clk); // idle gap
            run_case(i);
        end
        run_ext_and_soft_reset();

        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cmd_seq.f ====
+incdir+source
source/cmd_bus_pkg.sv
source/cmd_seq_pkg.sv
source/cmd_seq_regs.sv
source/cmd_seq_core.sv
source/cmd_line_encoder.sv
source/cmd_seq_top.sv
tests/tb_cmd_seq.sv

// ==== Makefile ====
# Verilator build and run for the command sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_seq
RTL_TOP   ?= cmd_seq_top
FILELIST  ?= cmd_seq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/cmd_seq_cases.txt ====
# conf size repeat start_rep stop_rep mem(4 bytes) len pairs(first pair leftmost) flags
# all columns hex; stream bit i is mem bit 31-i
00 0008 00000001 0000 0000 A5000000 08 CC33 80
00 0004 00000003 0000 0000 C0000000 0C F0F0F0 888
00 0008 00000002 0002 0002 B4000000 0C CF3F30 220
02 0008 00000001 0000 0000 A5000000 08 6619 80
04 0008 00000001 0000 0000 A5000000 08 6699 80
06 0008 00000001 0000 0000 A5000000 08 9966 80
10 0008 00000002 0000 0000 3C000000 10 0FF00FF0 0000
00 0010 00000000 0000 0000 12340000 10 030C0F30 8000
